/* dv/tb_lane_mem_ref.svh */
`ifndef tb_lane_mem_ref_svh
`define tb_lane_mem_ref_svh

// Byte images of both banks, indexed by byte position inside the bank
lane_t imem_ref [imem_words*lanes];
lane_t dmem_ref [dmem_words*lanes];

int mismatch_count = 0;
int other_errors   = 0;

function automatic int bank_depth(input bit dbank);
  return dbank ? dmem_words : imem_words;
endfunction

// Position of byte addr + k, with the word index folded into the bank
function automatic int byte_pos(input bit dbank, input addr_t addr, input int k);
  int depth;
  int word_idx;
  int pos;
  depth    = bank_depth(dbank);
  word_idx = int'((addr >> off_w) % depth);
  pos      = word_idx * lanes + int'(addr[off_w-1:0]);
  return (pos + k) % (depth * lanes);
endfunction

// Bytes written by each store op, unknown codes write nothing
function automatic int store_bytes(input store_op_t op);
  case (op)
    store_byte: return 1;
    store_half: return 2;
    store_word: return 4;
    default:    return 0;
  endcase
endfunction

// Byte k of din lands at byte address addr + k
function automatic void apply_store(input bit dbank, input addr_t addr,
                                    input word_t din, input store_op_t op);
  int n;
  int pos;
  n = store_bytes(op);
  for (int k = 0; k < n; k++) begin
    pos = byte_pos(dbank, addr, k);
    if (dbank) begin
      dmem_ref[pos] = din[byte_w*k +: byte_w];
    end else begin
      imem_ref[pos] = din[byte_w*k +: byte_w];
    end
  end
endfunction

// Byte k of the read word is the byte at addr + k
function automatic word_t expected_read(input bit dbank, input addr_t addr);
  word_t w;
  int    pos;
  w = '0;
  for (int k = 0; k < lanes; k++) begin
    pos = byte_pos(dbank, addr, k);
    w[byte_w*k +: byte_w] = dbank ? dmem_ref[pos] : imem_ref[pos];
  end
  return w;
endfunction

task automatic check_word(input string name, input word_t expected, input word_t actual);
  if (actual !== expected) begin
    mismatch_count++;
    $display("Mismatch %s: expected %h, actual %h at %0t", name, expected, actual, $time);
  end
endtask

`endif

/* dv/tb_lane_mem.sv */
module tb_lane_mem;
  timeunit 1ns;
  timeprecision 1ps;

  import lane_mem_pkg::*;

  localparam int reset_cycles   = 10;
  localparam int random_count   = 400;
  // Generous bound on the directed accesses after the fill
  localparam int directed_count = 200;
  localparam int fill_count     = (imem_words > dmem_words) ? imem_words : dmem_words;
  localparam int total_accesses = reset_cycles + fill_count + directed_count + random_count;
  localparam int clk_period     = 8;
  localparam int timeout_ns     = total_accesses * clk_period * 2 + 1000;

  logic      clk_1 = 1'b0;
  logic      rst_n_sync;

  logic      imem_en;
  addr_t     imem_addr;
  word_t     imem_din;
  store_op_t imem_store;
  word_t     imem_dout;

  logic      mem_en;
  addr_t     mem_addr;
  word_t     mem_din;
  store_op_t mem_store;
  word_t     mem_dout;

  // Compare is off while the fill reads still uninitialized words
  bit        compare_on;
  word_t     exp_imem;
  word_t     exp_dmem;

  `include "tb_lane_mem_ref.svh"

  lane_mem u_lane_mem (
    .clk_1     (clk_1),
    .rst_n_sync(rst_n_sync),
    .imem_en   (imem_en),
    .imem_addr (imem_addr),
    .imem_din  (imem_din),
    .imem_store(imem_store),
    .imem_dout (imem_dout),
    .mem_en    (mem_en),
    .mem_addr  (mem_addr),
    .mem_din   (mem_din),
    .mem_store (mem_store),
    .mem_dout  (mem_dout)
  );

  always #(clk_period / 2) clk_1 = ~clk_1;

  task automatic drive_port(input bit dbank, input logic en, input addr_t addr,
                            input word_t din, input store_op_t st);
    if (dbank) begin
      mem_en    <= en;
      mem_addr  <= addr;
      mem_din   <= din;
      mem_store <= st;
    end else begin
      imem_en    <= en;
      imem_addr  <= addr;
      imem_din   <= din;
      imem_store <= st;
    end
  endtask

  // One accepted access on one port with the other port idle
  task automatic access(input bit dbank, input addr_t addr, input word_t din,
                        input store_op_t st);
    @(posedge clk_1);
    drive_port(dbank, 1'b1, addr, din, st);
    drive_port(~dbank, 1'b0, '0, '0, store_none);
  endtask

  task automatic idle_both();
    @(posedge clk_1);
    drive_port(1'b0, 1'b0, '0, '0, store_none);
    drive_port(1'b1, 1'b0, '0, '0, store_none);
  endtask

  task automatic finish_run();
    $display("Mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Mixes every address bit and uses a different key per bank
  function automatic word_t fill_word(input bit dbank, input addr_t addr);
    return (addr * 32'h9e37_79b1) ^ (dbank ? 32'h5a5a_c3c3 : 32'h3c3c_a5a5);
  endfunction

  function automatic logic random_en();
    return $urandom_range(0, 3) != 0;
  endfunction

  // Includes two undefined codes that must behave like store_none
  function automatic store_op_t random_store();
    int r;
    r = $urandom_range(0, 10);
    case (r)
      0, 1, 2, 3: return store_none;
      4, 5:       return store_byte;
      6, 7:       return store_half;
      8:          return store_word;
      9:          return store_op_t'(3'b011);
      default:    return store_op_t'(3'b110);
    endcase
  endfunction

  // Mostly a small window so accesses overlap
  // Sometimes the bank top or any address at all
  function automatic addr_t random_addr(input bit dbank);
    int r;
    r = $urandom_range(0, 9);
    if (r < 6) begin
      return addr_t'($urandom_range(0, 63));
    end else if (r < 8) begin
      return addr_t'(bank_depth(dbank) * lanes - 8 + $urandom_range(0, 7));
    end
    return addr_t'($urandom());
  endfunction

  // Expected dout follows every accepted access and is read before the write
  always @(posedge clk_1) begin
    if (!rst_n_sync) begin
      exp_imem <= '0;
      exp_dmem <= '0;
    end else begin
      if (imem_en) begin
        exp_imem <= expected_read(1'b0, imem_addr);
        apply_store(1'b0, imem_addr, imem_din, imem_store);
      end
      if (mem_en) begin
        exp_dmem <= expected_read(1'b1, mem_addr);
        apply_store(1'b1, mem_addr, mem_din, mem_store);
      end
    end
  end

  always @(negedge clk_1) begin
    if (rst_n_sync && compare_on) begin
      check_word("imem_dout", exp_imem, imem_dout);
      check_word("mem_dout", exp_dmem, mem_dout);
    end
  end

  initial begin
    #(timeout_ns * 1ns);
    $display("Watchdog: run did not complete within %0d ns", timeout_ns);
    other_errors++;
    finish_run();
  end

  initial begin
    void'($urandom(65));
    rst_n_sync = 1'b0;
    compare_on = 1'b1;
    drive_port(1'b0, 1'b0, '0, '0, store_none);
    drive_port(1'b1, 1'b0, '0, '0, store_none);
    repeat (reset_cycles) @(posedge clk_1);
    rst_n_sync <= 1'b1;

    // Outputs are zero before the first access
    repeat (2) @(negedge clk_1);
    check_word("imem_dout", '0, imem_dout);
    check_word("mem_dout", '0, mem_dout);

    // Aligned word fill of both banks at once
    @(posedge clk_1);
    compare_on = 1'b0;
    for (int i = 0; i < fill_count; i++) begin
      @(posedge clk_1);
      for (int b = 0; b < 2; b++) begin
        drive_port(bit'(b), i < bank_depth(bit'(b)), addr_t'(i * lanes),
                   fill_word(bit'(b), addr_t'(i * lanes)), store_word);
      end
    end
    @(posedge clk_1);
    drive_port(1'b0, 1'b1, '0, '0, store_none);
    drive_port(1'b1, 1'b1, '0, '0, store_none);
    idle_both();
    compare_on = 1'b1;

    // Aligned read back on both ports together and then per-bank words
    for (int w = 0; w < 8; w++) begin
      @(posedge clk_1);
      drive_port(1'b0, 1'b1, addr_t'(((w * 37) % imem_words) * lanes), '0, store_none);
      drive_port(1'b1, 1'b1, addr_t'(((w * 37) % dmem_words) * lanes), '0, store_none);
    end
    access(1'b0, addr_t'(5 * lanes), 32'h1122_3344, store_word);
    access(1'b1, addr_t'(5 * lanes), 32'h99aa_bbcc, store_word);
    access(1'b0, addr_t'(5 * lanes), '0, store_none);
    access(1'b1, addr_t'(5 * lanes), '0, store_none);

    // Byte and half stores at every offset
    // The half store at offset 3 crosses into the next word
    for (int b = 0; b < 2; b++) begin
      for (int off = 0; off < lanes; off++) begin
        access(bit'(b), addr_t'(64 * lanes + off), word_t'($urandom()), store_byte);
        access(bit'(b), addr_t'(64 * lanes), '0, store_none);
        access(bit'(b), addr_t'(65 * lanes), '0, store_none);
      end
      for (int off = 0; off < lanes; off++) begin
        access(bit'(b), addr_t'(66 * lanes + off), word_t'($urandom()), store_half);
        access(bit'(b), addr_t'(66 * lanes), '0, store_none);
        access(bit'(b), addr_t'(67 * lanes), '0, store_none);
      end
    end

    // Misaligned reads, a word crossing, the bank top wrap and a high address
    for (int b = 0; b < 2; b++) begin
      for (int off = 1; off < lanes; off++) begin
        access(bit'(b), addr_t'(100 * lanes + off), '0, store_none);
        access(bit'(b), addr_t'((bank_depth(bit'(b)) - 1) * lanes + off), '0, store_none);
      end
      access(bit'(b), addr_t'(32'h0010_0000 + 100 * lanes + 2), '0, store_none);
    end

    // Store inputs with en low leave memory and dout alone
    for (int b = 0; b < 2; b++) begin
      access(bit'(b), addr_t'(200 * lanes), 32'hcafe_f00d, store_word);
      for (int n = 0; n < 4; n++) begin
        @(posedge clk_1);
        drive_port(bit'(b), 1'b0, addr_t'(200 * lanes + n), word_t'($urandom()), store_word);
        drive_port(~bit'(b), 1'b0, '0, '0, store_none);
      end
      access(bit'(b), addr_t'(200 * lanes), '0, store_none);
    end

    // Random traffic on both ports together
    for (int n = 0; n < random_count; n++) begin
      @(posedge clk_1);
      for (int b = 0; b < 2; b++) begin
        drive_port(bit'(b), random_en(), random_addr(bit'(b)), word_t'($urandom()),
                   random_store());
      end
    end

    idle_both();
    repeat (2) @(posedge clk_1);
    finish_run();
  end

endmodule

/* lane_mem.f */
+incdir+dv
src/lane_mem_pkg.sv
src/store_steer.sv
src/load_align.sv
src/mem_bank.sv
src/lane_mem.sv
dv/tb_lane_mem.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the lane_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lane_mem -f lane_mem.f -Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/Vtb_lane_mem" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if grep -qx "Done: no errors" "$log"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see $log"
exit 1

/* src/lane_mem.sv */
module lane_mem (
  input  logic                    clk_1,
  input  logic                    rst_n_sync,

  // Instruction port
  input  logic                    imem_en,
  input  lane_mem_pkg::addr_t     imem_addr,
  input  lane_mem_pkg::word_t     imem_din,
  input  lane_mem_pkg::store_op_t imem_store,
  output lane_mem_pkg::word_t     imem_dout,

  // Data port
  input  logic                    mem_en,
  input  lane_mem_pkg::addr_t     mem_addr,
  input  lane_mem_pkg::word_t     mem_din,
  input  lane_mem_pkg::store_op_t mem_store,
  output lane_mem_pkg::word_t     mem_dout
);

  import lane_mem_pkg::*;

  // Instruction bank, private to the fetch port
  mem_bank #(
    .words(imem_words)
  ) u_imem_bank (
    .clk_1     (clk_1),
    .rst_n_sync(rst_n_sync),
    .en        (imem_en),
    .addr      (imem_addr),
    .din       (imem_din),
    .store     (imem_store),
    .dout      (imem_dout)
  );

  // Data bank, private to the load/store port
  mem_bank #(
    .words(dmem_words)
  ) u_dmem_bank (
    .clk_1     (clk_1),
    .rst_n_sync(rst_n_sync),
    .en        (mem_en),
    .addr      (mem_addr),
    .din       (mem_din),
    .store     (mem_store),
    .dout      (mem_dout)
  );

endmodule

/* src/lane_mem_pkg.sv */
package lane_mem_pkg;

  // Lane geometry
  localparam int byte_w = 8;
  localparam int lanes  = 4;
  localparam int off_w  = 2;

  // Bank depths in 32-bit words
  localparam int imem_words = 1024;
  localparam int dmem_words = 1024;

  // Byte address as issued by the core
  typedef logic [31:0] addr_t;

  // Full data word, one byte per lane
  typedef logic [lanes*byte_w-1:0] word_t;

  // One byte lane
  typedef logic [byte_w-1:0] lane_t;

  // Byte offset inside a word
  typedef logic [off_w-1:0] off_t;

  // One write enable per lane
  typedef logic [lanes-1:0] lane_mask_t;

  // Store op as decoded by the core
  // Codes outside this list are treated like store_none
  typedef enum logic [2:0] {
    store_none = 3'b000,
    store_byte = 3'b001,
    store_half = 3'b010,
    store_word = 3'b100
  } store_op_t;

endpackage

/* src/load_align.sv */
module load_align (
  input  logic                clk_1,
  input  logic                rst_n_sync,
  input  logic                en,
  input  lane_mem_pkg::off_t  offset,
  input  lane_mem_pkg::lane_t lane_q [lane_mem_pkg::lanes],
  output lane_mem_pkg::word_t dout
);

  import lane_mem_pkg::*;

  off_t off_q;

  // Offset of the access whose lane bytes are in the read registers
  // Updated on the same edge as those registers
  always_ff @(posedge clk_1 or negedge rst_n_sync) begin
    if (!rst_n_sync) begin
      off_q <= '0;
    end else if (en) begin
      off_q <= offset;
    end
  end

  // Rotate down so the start byte lands in byte 0
  always_comb begin
    off_t src;
    for (int k = 0; k < lanes; k++) begin
      src = off_q + off_t'(k);
      dout[byte_w*k +: byte_w] = lane_q[src];
    end
  end

  // An unknown offset would scramble every later read word
  assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    !$isunknown(off_q))
    else $error("load_align: registered offset is unknown");

endmodule

/* src/mem_bank.sv */
module mem_bank #(
  parameter int words = 1024
) (
  input  logic                    clk_1,
  input  logic                    rst_n_sync,
  input  logic                    en,
  input  lane_mem_pkg::addr_t     addr,
  input  lane_mem_pkg::word_t     din,
  input  lane_mem_pkg::store_op_t store,
  output lane_mem_pkg::word_t     dout
);

  import lane_mem_pkg::*;

  // Word index inside this bank
  typedef logic [$clog2(words)-1:0] idx_t;

  idx_t       lane_idx [lanes];
  lane_t      lane_din [lanes];
  lane_t      lane_q   [lanes];
  lane_mask_t lane_we;

  // Per-lane index, byte and write enable for this access
  store_steer #(
    .words(words)
  ) u_store_steer (
    .addr    (addr),
    .din     (din),
    .store   (store),
    .en      (en),
    .lane_idx(lane_idx),
    .lane_din(lane_din),
    .lane_we (lane_we)
  );

  for (genvar j = 0; j < lanes; j++) begin : g_lane
    lane_t lane_ram [words];

    // Write port, already gated by en through the mask
    always_ff @(posedge clk_1) begin
      if (lane_we[j]) begin
        lane_ram[lane_idx[j]] <= lane_din[j];
      end
    end

    // Read port samples the array before the write above lands,
    // so a read of a location being stored returns the old byte
    always_ff @(posedge clk_1 or negedge rst_n_sync) begin
      if (!rst_n_sync) begin
        lane_q[j] <= '0;
      end else if (en) begin
        lane_q[j] <= lane_ram[lane_idx[j]];
      end
    end
  end

  // Bring the start byte down to the LSB
  load_align u_load_align (
    .clk_1     (clk_1),
    .rst_n_sync(rst_n_sync),
    .en        (en),
    .offset    (addr[off_w-1:0]),
    .lane_q    (lane_q),
    .dout      (dout)
  );

  // An idle port must never touch the arrays
  assert property (@(posedge clk_1) disable iff (!rst_n_sync)
    !en |-> (lane_we == '0))
    else $error("mem_bank: lane write enabled while en is low");

endmodule

/* src/store_steer.sv */
module store_steer #(
  parameter int words = 1024
) (
  input  lane_mem_pkg::addr_t      addr,
  input  lane_mem_pkg::word_t      din,
  input  lane_mem_pkg::store_op_t  store,
  input  logic                     en,
  output logic [$clog2(words)-1:0] lane_idx [lane_mem_pkg::lanes],
  output lane_mem_pkg::lane_t      lane_din [lane_mem_pkg::lanes],
  output lane_mem_pkg::lane_mask_t lane_we
);

  import lane_mem_pkg::*;

  typedef logic [$clog2(words)-1:0] idx_t;

  off_t               offset;
  idx_t               base_idx;
  idx_t               next_idx;
  lane_mask_t         span;
  logic [2*lanes-1:0] span_rot;

  assign offset = addr[off_w-1:0];

  // Word index of the start byte, folded into the bank
  assign base_idx = idx_t'(addr[$bits(addr_t)-1:off_w] % words);

  // Following word, wrapping from the last word back to word 0
  assign next_idx = (base_idx == idx_t'(words - 1)) ? '0 : base_idx + 1'b1;

  // Lanes below the start offset hold the tail of the access,
  // so they sit one word further on
  always_comb begin
    off_t src;
    for (int j = 0; j < lanes; j++) begin
      lane_idx[j] = (off_t'(j) < offset) ? next_idx : base_idx;
      // Lane j takes din byte (j - offset) mod 4
      src         = off_t'(j) - offset;
      lane_din[j] = din[byte_w*src +: byte_w];
    end
  end

  // Number of bytes written, packed at lane 0 before rotation
  always_comb begin
    case (store)
      store_byte: span = lane_mask_t'(4'b0001);
      store_half: span = lane_mask_t'(4'b0011);
      store_word: span = '1;
      default:    span = '0;
    endcase
  end

  // Rotate the span up to the start lane
  // The doubled copy lets lane 3 wrap around into lane 0
  assign span_rot = {span, span} << offset;
  assign lane_we  = en ? span_rot[2*lanes-1:lanes] : '0;

  // SB touches one lane and SH two, wherever the offset lands
  always_comb begin
    if (en && store == store_byte) begin
      assert final ($countones(lane_we) == 1)
        else $error("store_steer: byte store mask %b", lane_we);
    end
    if (en && store == store_half) begin
      assert final ($countones(lane_we) == 2)
        else $error("store_steer: half store mask %b", lane_we);
    end
  end

endmodule
